//--- bench/sec_mem_checks.svh
// Compare tasks and error counters for the secure memory testbench.
// Included inside the testbench module, after the package import.

`ifndef SEC_MEM_CHECKS_SVH
`define SEC_MEM_CHECKS_SVH

int value_errors = 0;
int other_errors = 0;

task automatic check_line(input string name, input line_t got, input line_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_opaque(input string name, input opaque_t got, input opaque_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_type(input string name, input mem_type_e got, input mem_type_e exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		value_errors++;
		$display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

`endif

//--- bench/sec_mem_tb.sv
// Testbench for the secure memory subsystem. Applies a table of requests on both
// ports with random response stalls, after a simultaneous start right after reset.

`timescale 1ns/1ps

module sec_mem_tb;
	import sec_mem_pkg::*;

	localparam int NUM_ROWS = 22;

	typedef struct packed {
		int        port;
		mem_type_e kind;
		logic      domain;
		addr_t     addr;
		line_t     data;
		opaque_t   opaque;
		line_t     exp_data;
		logic      exp_insecure;
	} row_t;

	logic      clk;
	logic      arst_n;
	logic      req_val [2];
	logic      req_rdy [2];
	mem_type_e req_type [2];
	opaque_t   req_opaque [2];
	addr_t     req_addr [2];
	line_t     req_data [2];
	logic      req_domain [2];
	logic      resp_val [2];
	logic      resp_rdy [2];
	mem_type_e resp_type [2];
	opaque_t   resp_opaque [2];
	line_t     resp_data [2];
	logic      resp_insecure [2];

	row_t        rows [NUM_ROWS];
	line_t       dv [6];
	logic [31:0] rng_state;

	`include "sec_mem_checks.svh"

	sec_mem_top i_dut (
		.clk            (clk),
		.arst_n         (arst_n),
		.req0_val       (req_val[0]),
		.req0_rdy       (req_rdy[0]),
		.req0_type      (req_type[0]),
		.req0_opaque    (req_opaque[0]),
		.req0_addr      (req_addr[0]),
		.req0_data      (req_data[0]),
		.req0_domain    (req_domain[0]),
		.req1_val       (req_val[1]),
		.req1_rdy       (req_rdy[1]),
		.req1_type      (req_type[1]),
		.req1_opaque    (req_opaque[1]),
		.req1_addr      (req_addr[1]),
		.req1_data      (req_data[1]),
		.req1_domain    (req_domain[1]),
		.resp0_val      (resp_val[0]),
		.resp0_rdy      (resp_rdy[0]),
		.resp0_type     (resp_type[0]),
		.resp0_opaque   (resp_opaque[0]),
		.resp0_data     (resp_data[0]),
		.resp0_insecure (resp_insecure[0]),
		.resp1_val      (resp_val[1]),
		.resp1_rdy      (resp_rdy[1]),
		.resp1_type     (resp_type[1]),
		.resp1_opaque   (resp_opaque[1]),
		.resp1_data     (resp_data[1]),
		.resp1_insecure (resp_insecure[1])
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// about 50 cycles per row is plenty, even with the longest stall
	initial begin
		repeat (NUM_ROWS * 50 + 200) @(posedge clk);
		$display("watchdog expired before the request table finished");
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic row_t make_row(input int p, input mem_type_e k, input logic dom,
			input addr_t a, input line_t d, input opaque_t o, input line_t ed, input logic ei);
		row_t r;
		r.port         = p;
		r.kind         = k;
		r.domain       = dom;
		r.addr         = a;
		r.data         = d;
		r.opaque       = o;
		r.exp_data     = ed;
		r.exp_insecure = ei;
		return r;
	endfunction

	// ==================================================
	// request table
	// ==================================================

	task automatic build_table();
		line_t cfg_8000;
		line_t cfg_4000;
		line_t par_8000;
		for (int i = 0; i < 6; i++)
			dv[i] = {next_rand(), next_rand(), next_rand(), next_rand()};
		// upper bits are noise, only the low word reaches the partition
		cfg_8000 = {dv[2][127:32], 32'h0000_8000};
		cfg_4000 = {dv[3][127:32], 32'h0000_4000};
		par_8000 = 128'h0000_8000;
		// rows 0 and 1 start together right after reset
		rows[0]  = make_row(0, MEM_WRITE, 1'b1, 32'h0000_0400, dv[4], 8'h40, '0, 1'b0);
		rows[1]  = make_row(1, MEM_WRITE, 1'b1, 32'h0000_0500, dv[5], 8'h41, '0, 1'b0);
		rows[2]  = make_row(0, MEM_WRITE, 1'b1, 32'h0000_0100, dv[0], 8'h42, '0, 1'b0);
		rows[3]  = make_row(0, MEM_READ, 1'b1, 32'h0000_0100, '0, 8'h43, dv[0], 1'b0);
		rows[4]  = make_row(1, MEM_WRITE, 1'b1, 32'h0000_2000, dv[1], 8'h44, '0, 1'b0);
		rows[5]  = make_row(1, MEM_READ, 1'b1, 32'h0000_2000, '0, 8'h45, dv[1], 1'b0);
		rows[6]  = make_row(1, MEM_READ, 1'b1, 32'h0000_0400, '0, 8'h46, dv[4], 1'b0);
		rows[7]  = make_row(0, MEM_READ, 1'b1, 32'h0000_0500, '0, 8'h47, dv[5], 1'b0);
		// protected region above the reset partition
		rows[8]  = make_row(0, MEM_WRITE, 1'b1, 32'h0000_C000, dv[2], 8'h48, '0, 1'b0);
		rows[9]  = make_row(1, MEM_READ, 1'b0, 32'h0000_C000, '0, 8'h49, '0, 1'b1);
		rows[10] = make_row(1, MEM_WRITE, 1'b0, 32'h0000_C000, dv[3], 8'h4a, '0, 1'b1);
		rows[11] = make_row(0, MEM_READ, 1'b1, 32'h0000_C000, '0, 8'h4b, dv[2], 1'b0);
		rows[12] = make_row(1, MEM_READ, 1'b0, 32'h0000_0100, '0, 8'h4c, dv[0], 1'b0);
		rows[13] = make_row(0, MEM_WRITE, 1'b0, 32'h0000_9000, dv[3], 8'h4d, '0, 1'b0);
		// partition moves down to 0x8000
		rows[14] = make_row(0, MEM_WRITE, 1'b1, PAR_CFG_ADDR, cfg_8000, 8'h4e, '0, 1'b0);
		rows[15] = make_row(1, MEM_READ, 1'b0, 32'h0000_9000, '0, 8'h4f, '0, 1'b1);
		rows[16] = make_row(0, MEM_READ, 1'b1, PAR_CFG_ADDR, '0, 8'h50, par_8000, 1'b0);
		rows[17] = make_row(1, MEM_WRITE, 1'b0, PAR_CFG_ADDR, cfg_4000, 8'h51, '0, 1'b1);
		rows[18] = make_row(1, MEM_READ, 1'b1, PAR_CFG_ADDR, '0, 8'h52, par_8000, 1'b0);
		rows[19] = make_row(0, MEM_READ, 1'b1, 32'h0000_9000, '0, 8'h53, dv[3], 1'b0);
		rows[20] = make_row(1, MEM_READ, 1'b0, 32'h0000_2000, '0, 8'h54, dv[1], 1'b0);
		rows[21] = make_row(0, MEM_READ, 1'b0, 32'h0000_8000, '0, 8'h55, '0, 1'b1);
	endtask

	// ==================================================
	// request and response handling
	// ==================================================

	task automatic drive_req(input row_t r, input logic val);
		req_val[r.port]    = val;
		req_type[r.port]   = r.kind;
		req_opaque[r.port] = r.opaque;
		req_addr[r.port]   = r.addr;
		req_data[r.port]   = r.data;
		req_domain[r.port] = r.domain;
	endtask

	// returns on the accepting edge
	task automatic wait_accept(input int p);
		int guard;
		guard = 0;
		@(negedge clk);
		while (!req_rdy[p] && guard < 20) begin
			@(negedge clk);
			guard++;
		end
		if (!req_rdy[p]) begin
			other_errors++;
			$display("port %0d request not accepted within %0d cycles at %0t", p, guard, $time);
		end
		@(posedge clk);
	endtask

	task automatic wait_resp(input row_t r);
		int    edges;
		int    p;
		string tag;
		p = r.port;
		tag = $sformatf("resp%0d_", p);
		edges = 1;
		@(negedge clk);
		while (!resp_val[p] && edges < 20) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		if (!resp_val[p]) begin
			other_errors++;
			$display("no response on port %0d after %0d edges at %0t", p, edges, $time);
		end else begin
			// accepting edge counts as the first
			check_count({tag, "latency"}, edges, 3);
			check_type({tag, "type"}, resp_type[p], r.kind);
			check_opaque({tag, "opaque"}, resp_opaque[p], r.opaque);
			check_line({tag, "data"}, resp_data[p], r.exp_data);
			check_bit({tag, "insecure"}, resp_insecure[p], r.exp_insecure);
			check_bit($sformatf("resp%0d_val", 1 - p), resp_val[1 - p], 1'b0);
		end
	endtask

	task automatic run_row(input row_t r);
		int    stall;
		string tag;
		stall = int'(next_rand() % 32'd4);
		tag = $sformatf("resp%0d_", r.port);
		@(posedge clk);
		#1;
		drive_req(r, 1'b1);
		wait_accept(r.port);
		#1;
		drive_req(r, 1'b0);
		wait_resp(r);
		// response held, both ports blocked while stalled
		repeat (stall) begin
			@(posedge clk);
			@(negedge clk);
			check_bit({tag, "val"}, resp_val[r.port], 1'b1);
			check_line({tag, "data"}, resp_data[r.port], r.exp_data);
			check_bit({tag, "insecure"}, resp_insecure[r.port], r.exp_insecure);
			check_bit("req0_rdy", req_rdy[0], 1'b0);
			check_bit("req1_rdy", req_rdy[1], 1'b0);
		end
		@(posedge clk);
		#1;
		resp_rdy[r.port] = 1'b1;
		@(posedge clk);
		#1;
		resp_rdy[r.port] = 1'b0;
		@(negedge clk);
		check_bit({tag, "val"}, resp_val[r.port], 1'b0);
		check_bit("req0_rdy", req_rdy[0], 1'b1);
		check_bit("req1_rdy", req_rdy[1], 1'b1);
	endtask

	task automatic run_pair(input row_t a, input row_t b);
		@(posedge clk);
		#1;
		drive_req(a, 1'b1);
		drive_req(b, 1'b1);
		resp_rdy[0] = 1'b1;
		resp_rdy[1] = 1'b1;
		@(negedge clk);
		// port 0 wins first after reset
		check_bit("req0_rdy", req_rdy[0], 1'b1);
		check_bit("req1_rdy", req_rdy[1], 1'b0);
		@(posedge clk);
		#1;
		drive_req(a, 1'b0);
		wait_resp(a);
		wait_accept(b.port);
		#1;
		drive_req(b, 1'b0);
		wait_resp(b);
		@(posedge clk);
		#1;
		resp_rdy[0] = 1'b0;
		resp_rdy[1] = 1'b0;
	endtask

	initial begin
		arst_n = 1'b0;
		rng_state = 32'd65;
		for (int i = 0; i < 2; i++) begin
			req_val[i]    = 1'b0;
			req_type[i]   = MEM_READ;
			req_opaque[i] = '0;
			req_addr[i]   = '0;
			req_data[i]   = '0;
			req_domain[i] = 1'b0;
			resp_rdy[i]   = 1'b0;
		end
		build_table();
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		check_bit("req0_rdy", req_rdy[0], 1'b1);
		check_bit("req1_rdy", req_rdy[1], 1'b1);
		check_bit("resp0_val", resp_val[0], 1'b0);
		check_bit("resp1_val", resp_val[1], 1'b0);
		check_bit("go", i_dut.go, 1'b0);
		check_bit("done", i_dut.done, 1'b0);
		check_bit("mem_en", i_dut.mem_en, 1'b0);
		run_pair(rows[0], rows[1]);
		for (int i = 2; i < NUM_ROWS; i++)
			run_row(rows[i]);
		repeat (4) @(posedge clk);
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+bench
src/sec_mem_pkg.sv
src/mem_arbiter.sv
src/mem_addr_ctrl.sv
src/line_mem.sv
src/sec_mem_top.sv
bench/sec_mem_tb.sv

//--- run.sh
#!/bin/sh
# Builds the secure memory testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f compile.f --top-module sec_mem_tb \
	-Mdir obj_dir -o sec_mem_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sec_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "Test passed" sim.log; then
	echo "no result line found in sim.log"
	exit 1
fi
exit 0

//--- src/line_mem.sv
// Line-wide main memory, one line per access.
// Synchronous write, read data registered and valid the cycle after mem_en.

`timescale 1ns/1ps

module line_mem (
	input  logic                   clk,
	input  logic                   mem_en,
	input  logic                   mem_we,
	input  sec_mem_pkg::line_idx_t mem_idx,
	input  sec_mem_pkg::line_t     mem_wdata,
	output sec_mem_pkg::line_t     mem_rdata
);
	import sec_mem_pkg::*;

	line_t mem [MEM_NLINES];

	// read returns the old line on a write, responses drop it anyway
	always_ff @(posedge clk) begin
		if (mem_en) begin
			if (mem_we)
				mem[mem_idx] <= mem_wdata;
			mem_rdata <= mem[mem_idx];
		end
	end

endmodule

//--- src/mem_addr_ctrl.sv
// Address access controller. Checks each request's domain against the partition,
// handles partition reads and writes, and drives the line memory.

`timescale 1ns/1ps

module mem_addr_ctrl (
	input  logic                   clk,
	input  logic                   arst_n,

	input  logic                   go,
	input  sec_mem_pkg::mem_type_e go_type,
	input  sec_mem_pkg::addr_t     go_addr,
	input  sec_mem_pkg::line_t     go_data,
	input  logic                   go_domain,

	output logic                   done,
	output sec_mem_pkg::line_t     done_rdata,
	output logic                   done_insecure,

	output logic                   mem_en,
	output logic                   mem_we,
	output sec_mem_pkg::line_idx_t mem_idx,
	output sec_mem_pkg::line_t     mem_wdata,
	input  sec_mem_pkg::line_t     mem_rdata
);
	import sec_mem_pkg::*;

	addr_t par;
	logic  is_cfg;
	logic  is_write;
	logic  deny;

	// second stage lines up with the memory read data
	logic  done_q;
	logic  deny_q;
	logic  cfg_q;
	logic  read_q;
	addr_t par_q;

	// ==================================================
	// request decode
	// ==================================================

	assign is_cfg   = (go_addr == PAR_CFG_ADDR);
	assign is_write = (go_type == MEM_WRITE);

	// insecure side may not touch anything at or above the partition
	assign deny = !go_domain && (is_cfg || (go_addr >= par));

	assign mem_en    = go && !deny && !is_cfg;
	assign mem_we    = is_write;
	assign mem_idx   = go_addr[LINE_OFF_NBITS +: LINE_IDX_NBITS];
	assign mem_wdata = go_data;

	// partition register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			par <= INITIAL_PAR;
		else if (go && go_domain && is_cfg && is_write)
			par <= go_data[ADDR_NBITS-1:0];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			done_q <= 1'b0;
		else
			done_q <= go;
	end

	always_ff @(posedge clk) begin
		if (go) begin
			deny_q <= deny;
			cfg_q  <= is_cfg;
			read_q <= !is_write;
			par_q  <= par;
		end
	end

	// ==================================================
	// response
	// ==================================================

	assign done          = done_q;
	assign done_insecure = deny_q;

	always_comb begin
		if (deny_q || !read_q)
			done_rdata = '0;
		else if (cfg_q)
			done_rdata = {{(LINE_NBITS-ADDR_NBITS){1'b0}}, par_q};
		else
			done_rdata = mem_rdata;
	end

	// no memory access for an insecure request at or above the partition
	assert property (@(posedge clk) disable iff (!arst_n)
		mem_en |-> (go_addr != PAR_CFG_ADDR) && (go_domain || (go_addr < par)));

endmodule

//--- src/mem_arbiter.sv
// Round-robin arbiter for the cache refill port (0) and the DMA port (1).
// Holds one transaction at a time and returns the response to the port that won.

`timescale 1ns/1ps

module mem_arbiter (
	input  logic                  clk,
	input  logic                  arst_n,

	input  logic                  req0_val,
	output logic                  req0_rdy,
	input  sec_mem_pkg::mem_type_e req0_type,
	input  sec_mem_pkg::opaque_t  req0_opaque,
	input  sec_mem_pkg::addr_t    req0_addr,
	input  sec_mem_pkg::line_t    req0_data,
	input  logic                  req0_domain,

	input  logic                  req1_val,
	output logic                  req1_rdy,
	input  sec_mem_pkg::mem_type_e req1_type,
	input  sec_mem_pkg::opaque_t  req1_opaque,
	input  sec_mem_pkg::addr_t    req1_addr,
	input  sec_mem_pkg::line_t    req1_data,
	input  logic                  req1_domain,

	output logic                  resp0_val,
	input  logic                  resp0_rdy,
	output sec_mem_pkg::mem_type_e resp0_type,
	output sec_mem_pkg::opaque_t  resp0_opaque,
	output sec_mem_pkg::line_t    resp0_data,
	output logic                  resp0_insecure,

	output logic                  resp1_val,
	input  logic                  resp1_rdy,
	output sec_mem_pkg::mem_type_e resp1_type,
	output sec_mem_pkg::opaque_t  resp1_opaque,
	output sec_mem_pkg::line_t    resp1_data,
	output logic                  resp1_insecure,

	output logic                  go,
	output sec_mem_pkg::mem_type_e go_type,
	output sec_mem_pkg::addr_t    go_addr,
	output sec_mem_pkg::line_t    go_data,
	output logic                  go_domain,

	input  logic                  done,
	input  sec_mem_pkg::line_t    done_rdata,
	input  logic                  done_insecure
);
	import sec_mem_pkg::*;

	logic    busy;
	logic    gnt_idx;
	logic    grant0;
	logic    grant1;
	logic    accept0;
	logic    accept1;
	logic    resp_taken;
	opaque_t opaque_q;

	// gnt_idx doubles as the round-robin pointer, reset to 1 so port 0 wins first
	assign grant0 = !busy && (!req1_val || gnt_idx);
	assign grant1 = !busy && (!req0_val || !gnt_idx);

	assign req0_rdy = grant0;
	assign req1_rdy = grant1;
	assign accept0  = req0_val && grant0;
	assign accept1  = req1_val && grant1;

	assign resp_taken = (resp0_val && resp0_rdy) || (resp1_val && resp1_rdy);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy    <= 1'b0;
			gnt_idx <= 1'b1;
			go      <= 1'b0;
		end else begin
			go <= accept0 || accept1;
			if (accept0 || accept1) begin
				busy    <= 1'b1;
				gnt_idx <= accept1;
			end else if (resp_taken) begin
				busy <= 1'b0;
			end
		end
	end

	// request held stable while busy, type also echoed back
	always_ff @(posedge clk) begin
		if (accept0 || accept1) begin
			go_type   <= accept1 ? req1_type : req0_type;
			go_addr   <= accept1 ? req1_addr : req0_addr;
			go_data   <= accept1 ? req1_data : req0_data;
			go_domain <= accept1 ? req1_domain : req0_domain;
			opaque_q  <= accept1 ? req1_opaque : req0_opaque;
		end
	end

	// ==================================================
	// response registers
	// ==================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp0_val <= 1'b0;
			resp1_val <= 1'b0;
		end else begin
			if (done && !gnt_idx)
				resp0_val <= 1'b1;
			else if (resp0_rdy)
				resp0_val <= 1'b0;
			if (done && gnt_idx)
				resp1_val <= 1'b1;
			else if (resp1_rdy)
				resp1_val <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (done && !gnt_idx) begin
			resp0_type     <= go_type;
			resp0_opaque   <= opaque_q;
			resp0_data     <= done_rdata;
			resp0_insecure <= done_insecure;
		end
		if (done && gnt_idx) begin
			resp1_type     <= go_type;
			resp1_opaque   <= opaque_q;
			resp1_data     <= done_rdata;
			resp1_insecure <= done_insecure;
		end
	end

	// one transaction in flight, so never two responses
	assert property (@(posedge clk) disable iff (!arst_n) !(resp0_val && resp1_val));

endmodule

//--- src/sec_mem_pkg.sv
// Widths, types and address constants shared by the secure memory subsystem.
// Modules import this package inside their bodies and use scoped names in port lists.

package sec_mem_pkg;

	// ==================================================
	// widths and sizes
	// ==================================================

	localparam int ADDR_NBITS     = 32;
	localparam int LINE_NBITS     = 128;
	localparam int OPAQUE_NBITS   = 8;
	localparam int MEM_NBYTES     = 1 << 16;
	localparam int LINE_IDX_NBITS = 12;

	// byte offset inside a line, line index sits right above it
	localparam int LINE_OFF_NBITS = 4;
	localparam int MEM_NLINES     = MEM_NBYTES / (LINE_NBITS / 8);

	// ==================================================
	// address map
	// ==================================================

	// data-side partition after reset
	localparam logic [ADDR_NBITS-1:0] INITIAL_PAR  = 32'h0000_C000;

	// partition register, outside the memory array
	localparam logic [ADDR_NBITS-1:0] PAR_CFG_ADDR = 32'h0001_0000;

	// ==================================================
	// types
	// ==================================================

	typedef logic [ADDR_NBITS-1:0]     addr_t;
	typedef logic [LINE_NBITS-1:0]     line_t;
	typedef logic [OPAQUE_NBITS-1:0]   opaque_t;
	typedef logic [LINE_IDX_NBITS-1:0] line_idx_t;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_type_e;

endpackage

//--- src/sec_mem_top.sv
// Secure memory subsystem top. Two request ports share one line memory
// through the arbiter and the address access controller.

`timescale 1ns/1ps

module sec_mem_top (
	input  logic                   clk,
	input  logic                   arst_n,

	input  logic                   req0_val,
	output logic                   req0_rdy,
	input  sec_mem_pkg::mem_type_e req0_type,
	input  sec_mem_pkg::opaque_t   req0_opaque,
	input  sec_mem_pkg::addr_t     req0_addr,
	input  sec_mem_pkg::line_t     req0_data,
	input  logic                   req0_domain,

	input  logic                   req1_val,
	output logic                   req1_rdy,
	input  sec_mem_pkg::mem_type_e req1_type,
	input  sec_mem_pkg::opaque_t   req1_opaque,
	input  sec_mem_pkg::addr_t     req1_addr,
	input  sec_mem_pkg::line_t     req1_data,
	input  logic                   req1_domain,

	output logic                   resp0_val,
	input  logic                   resp0_rdy,
	output sec_mem_pkg::mem_type_e resp0_type,
	output sec_mem_pkg::opaque_t   resp0_opaque,
	output sec_mem_pkg::line_t     resp0_data,
	output logic                   resp0_insecure,

	output logic                   resp1_val,
	input  logic                   resp1_rdy,
	output sec_mem_pkg::mem_type_e resp1_type,
	output sec_mem_pkg::opaque_t   resp1_opaque,
	output sec_mem_pkg::line_t     resp1_data,
	output logic                   resp1_insecure
);
	import sec_mem_pkg::*;

	// arbiter to access controller
	logic      go;
	mem_type_e go_type;
	addr_t     go_addr;
	line_t     go_data;
	logic      go_domain;
	logic      done;
	line_t     done_rdata;
	logic      done_insecure;

	// access controller to memory
	logic      mem_en;
	logic      mem_we;
	line_idx_t mem_idx;
	line_t     mem_wdata;
	line_t     mem_rdata;

	mem_arbiter i_arbiter (
		.clk            (clk),
		.arst_n         (arst_n),
		.req0_val       (req0_val),
		.req0_rdy       (req0_rdy),
		.req0_type      (req0_type),
		.req0_opaque    (req0_opaque),
		.req0_addr      (req0_addr),
		.req0_data      (req0_data),
		.req0_domain    (req0_domain),
		.req1_val       (req1_val),
		.req1_rdy       (req1_rdy),
		.req1_type      (req1_type),
		.req1_opaque    (req1_opaque),
		.req1_addr      (req1_addr),
		.req1_data      (req1_data),
		.req1_domain    (req1_domain),
		.resp0_val      (resp0_val),
		.resp0_rdy      (resp0_rdy),
		.resp0_type     (resp0_type),
		.resp0_opaque   (resp0_opaque),
		.resp0_data     (resp0_data),
		.resp0_insecure (resp0_insecure),
		.resp1_val      (resp1_val),
		.resp1_rdy      (resp1_rdy),
		.resp1_type     (resp1_type),
		.resp1_opaque   (resp1_opaque),
		.resp1_data     (resp1_data),
		.resp1_insecure (resp1_insecure),
		.go             (go),
		.go_type        (go_type),
		.go_addr        (go_addr),
		.go_data        (go_data),
		.go_domain      (go_domain),
		.done           (done),
		.done_rdata     (done_rdata),
		.done_insecure  (done_insecure)
	);

	mem_addr_ctrl i_addr_ctrl (
		.clk           (clk),
		.arst_n        (arst_n),
		.go            (go),
		.go_type       (go_type),
		.go_addr       (go_addr),
		.go_data       (go_data),
		.go_domain     (go_domain),
		.done          (done),
		.done_rdata    (done_rdata),
		.done_insecure (done_insecure),
		.mem_en        (mem_en),
		.mem_we        (mem_we),
		.mem_idx       (mem_idx),
		.mem_wdata     (mem_wdata),
		.mem_rdata     (mem_rdata)
	);

	line_mem i_line_mem (
		.clk       (clk),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_idx   (mem_idx),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

endmodule
